// ==== rtl/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;

    // widest line the structs can carry
    localparam int LINE_WORDS_MAX = 8;

    typedef logic [LINE_WORDS_MAX*32-1:0] line_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } fetch_req_t;

    typedef struct packed {
        logic  valid;
        word_t data;
    } fetch_rsp_t;

    typedef struct packed {
        logic  valid;
        logic  write;
        strb_t strb;
        addr_t addr;
        word_t wdata;
    } data_req_t;

    typedef struct packed {
        logic  valid;
        word_t rdata;
    } data_rsp_t;

    // addr is line aligned, line holds the write data
    typedef struct packed {
        logic  valid;
        logic  write;
        addr_t addr;
        line_t line;
    } mem_req_t;

    typedef struct packed {
        logic  valid;
        line_t line;
    } mem_rsp_t;

    typedef enum logic [1:0] {
        IDLE,
        WRITE_BACK,
        REFILL,
        RESPOND
    } refill_state_t;

endpackage

`default_nettype wire

// ==== rtl/cache_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_array
    import cache_pkg::*;
#(
    parameter  int LINE_WORDS = 4,
    parameter  int SETS       = 16,
    localparam int IDX_W      = $clog2(SETS),
    localparam int TAG_W      = 32 - IDX_W - $clog2(LINE_WORDS * 4)
) (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic [IDX_W-1:0] index_i,
    input  logic [TAG_W-1:0] tag_i,
    input  logic             line_we_i,
    input  line_t            line_i,
    input  logic             dirty_i,
    output logic             valid_o,
    output logic             dirty_o,
    output logic [TAG_W-1:0] tag_o,
    output line_t            line_o
);

    localparam int LINE_W = LINE_WORDS * 32;

    typedef logic [IDX_W-1:0] index_t;
    typedef logic [TAG_W-1:0] tag_t;

    index_t            index_q;
    logic [SETS-1:0]   valid_q;
    logic [SETS-1:0]   dirty_q;
    tag_t              tag_mem  [SETS];
    logic [LINE_W-1:0] line_mem [SETS];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            index_q <= '0;
        end else begin
            index_q <= index_i;
        end
    end

    // a write always lands in the set being looked up this cycle
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (line_we_i) begin
            valid_q[index_q] <= 1'b1;
            dirty_q[index_q] <= dirty_i;
        end
    end

    always_ff @(posedge clk) begin
        if (line_we_i) begin
            tag_mem[index_q]  <= tag_i;
            line_mem[index_q] <= line_i[LINE_W-1:0];
        end
    end

    assign valid_o = valid_q[index_q];
    assign dirty_o = dirty_q[index_q];
    assign tag_o   = tag_mem[index_q];

    // upper words of the wide line type stay zero
    always_comb begin
        line_o = '0;
        line_o[LINE_W-1:0] = line_mem[index_q];
    end

endmodule

`default_nettype wire

// ==== rtl/icache.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache
    import cache_pkg::*;
#(
    parameter int LINE_WORDS = 4,
    parameter int SETS       = 16
) (
    input  logic       clk,
    input  logic       rst_n_i,
    input  fetch_req_t req_i,
    output fetch_rsp_t rsp_o,
    output logic       stall_o,
    output mem_req_t   mem_req_o,
    input  logic       mem_grant_i,
    input  mem_rsp_t   mem_rsp_i
);

    localparam int OFF_W = $clog2(LINE_WORDS * 4);
    localparam int IDX_W = $clog2(SETS);
    localparam int TAG_W = 32 - IDX_W - OFF_W;

    typedef logic [IDX_W-1:0] index_t;
    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [OFF_W-3:0] word_sel_t;

    refill_state_t state_q;
    logic          pend_q;
    logic          issued_q;
    addr_t         addr_q;
    logic          accept;
    logic          hit;
    index_t        index;
    word_sel_t     word_sel;
    logic          arr_valid;
    tag_t          arr_tag;
    line_t         arr_line;

    assign hit      = arr_valid && (arr_tag == addr_q[31 -: TAG_W]);
    assign stall_o  = (state_q == IDLE && pend_q && !hit) || state_q == REFILL;
    assign accept   = req_i.valid && !stall_o;
    // hold the miss set while stalled, else look up the incoming fetch
    assign index    = stall_o ? addr_q[OFF_W +: IDX_W] : req_i.addr[OFF_W +: IDX_W];
    assign word_sel = addr_q[OFF_W-1:2];

    assign rsp_o.valid = (state_q == IDLE && pend_q && hit) || state_q == RESPOND;
    assign rsp_o.data  = arr_line[word_sel * 32 +: 32];

    always_comb begin
        mem_req_o       = '0;
        mem_req_o.valid = state_q == REFILL && !issued_q;
        mem_req_o.addr  = {addr_q[31:OFF_W], {OFF_W{1'b0}}};
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q  <= IDLE;
            pend_q   <= 1'b0;
            issued_q <= 1'b0;
        end else begin
            if (!stall_o) begin
                pend_q <= req_i.valid;
            end
            case (state_q)
                IDLE: begin
                    if (pend_q && !hit) begin
                        state_q <= REFILL;
                    end
                end
                REFILL: begin
                    if (mem_grant_i) begin
                        issued_q <= 1'b1;
                    end
                    if (mem_rsp_i.valid) begin
                        state_q  <= RESPOND;
                        issued_q <= 1'b0;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= req_i.addr;
        end
    end

    cache_array #(
        .LINE_WORDS (LINE_WORDS),
        .SETS       (SETS)
    ) u_array (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .index_i   (index),
        .tag_i     (addr_q[31 -: TAG_W]),
        .line_we_i (state_q == REFILL && mem_rsp_i.valid),
        .line_i    (mem_rsp_i.line),
        .dirty_i   (1'b0),
        .valid_o   (arr_valid),
        .dirty_o   (),
        .tag_o     (arr_tag),
        .line_o    (arr_line)
    );

endmodule

`default_nettype wire

// ==== rtl/dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache
    import cache_pkg::*;
#(
    parameter int LINE_WORDS = 4,
    parameter int SETS       = 16
) (
    input  logic      clk,
    input  logic      rst_n_i,
    input  data_req_t req_i,
    output data_rsp_t rsp_o,
    output logic      stall_o,
    output mem_req_t  mem_req_o,
    input  logic      mem_grant_i,
    input  mem_rsp_t  mem_rsp_i
);

    localparam int OFF_W = $clog2(LINE_WORDS * 4);
    localparam int IDX_W = $clog2(SETS);
    localparam int TAG_W = 32 - IDX_W - OFF_W;

    typedef logic [IDX_W-1:0] index_t;
    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [OFF_W-3:0] word_sel_t;

    refill_state_t state_q;
    logic          pend_q;
    logic          issued_q;
    addr_t         addr_q;
    logic          write_q;
    strb_t         strb_q;
    word_t         wdata_q;
    logic          accept;
    logic          hit;
    index_t        index;
    word_sel_t     word_sel;
    line_t         base_line;
    line_t         merged_line;
    logic          line_we;
    logic          arr_valid;
    logic          arr_dirty;
    tag_t          arr_tag;
    line_t         arr_line;

    function automatic line_t merge_word(line_t base, word_sel_t sel, strb_t strb,
                                         word_t wdata);
        line_t result;
        result = base;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                result[sel * 32 + b * 8 +: 8] = wdata[b * 8 +: 8];
            end
        end
        return result;
    endfunction

    assign hit      = arr_valid && (arr_tag == addr_q[31 -: TAG_W]);
    assign stall_o  = (state_q == IDLE && pend_q && !hit) ||
                      state_q == WRITE_BACK || state_q == REFILL;
    assign accept   = req_i.valid && !stall_o;
    assign index    = stall_o ? addr_q[OFF_W +: IDX_W] : req_i.addr[OFF_W +: IDX_W];
    assign word_sel = addr_q[OFF_W-1:2];

    // a load merges nothing, so one path serves loads and stores
    assign base_line   = (state_q == REFILL) ? mem_rsp_i.line : arr_line;
    assign merged_line = merge_word(base_line, word_sel, write_q ? strb_q : 4'b0000, wdata_q);
    assign line_we     = (state_q == IDLE && pend_q && hit && write_q) ||
                         (state_q == REFILL && mem_rsp_i.valid);

    assign rsp_o.valid = (state_q == IDLE && pend_q && hit) || state_q == RESPOND;
    assign rsp_o.rdata = merged_line[word_sel * 32 +: 32];

    // victim stays visible in the array until the refill writes over it
    always_comb begin
        mem_req_o = '0;
        if (state_q == WRITE_BACK) begin
            mem_req_o.valid = 1'b1;
            mem_req_o.write = 1'b1;
            mem_req_o.addr  = {arr_tag, addr_q[OFF_W +: IDX_W], {OFF_W{1'b0}}};
            mem_req_o.line  = arr_line;
        end else begin
            mem_req_o.valid = state_q == REFILL && !issued_q;
            mem_req_o.addr  = {addr_q[31:OFF_W], {OFF_W{1'b0}}};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q  <= IDLE;
            pend_q   <= 1'b0;
            issued_q <= 1'b0;
        end else begin
            if (!stall_o) begin
                pend_q <= req_i.valid;
            end
            case (state_q)
                IDLE: begin
                    if (pend_q && !hit) begin
                        state_q <= (arr_valid && arr_dirty) ? WRITE_BACK : REFILL;
                    end
                end
                WRITE_BACK: begin
                    if (mem_grant_i) begin
                        state_q <= REFILL;
                    end
                end
                REFILL: begin
                    if (mem_grant_i) begin
                        issued_q <= 1'b1;
                    end
                    if (mem_rsp_i.valid) begin
                        state_q  <= RESPOND;
                        issued_q <= 1'b0;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= req_i.addr;
            write_q <= req_i.write;
            strb_q  <= req_i.strb;
            wdata_q <= req_i.wdata;
        end
    end

    cache_array #(
        .LINE_WORDS (LINE_WORDS),
        .SETS       (SETS)
    ) u_array (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .index_i   (index),
        .tag_i     (addr_q[31 -: TAG_W]),
        .line_we_i (line_we),
        .line_i    (merged_line),
        .dirty_i   (write_q),
        .valid_o   (arr_valid),
        .dirty_o   (arr_dirty),
        .tag_o     (arr_tag),
        .line_o    (arr_line)
    );

endmodule

`default_nettype wire

// ==== rtl/mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter
    import cache_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n_i,
    input  mem_req_t ic_req_i,
    input  mem_req_t dc_req_i,
    output logic     ic_grant_o,
    output logic     dc_grant_o,
    output mem_rsp_t ic_rsp_o,
    output mem_rsp_t dc_rsp_o,
    output mem_req_t mem_req_o,
    input  logic     mem_ready_i,
    input  mem_rsp_t mem_rsp_i
);

    // busy from first grant to the read response
    logic     busy_q;
    // a presented request waiting on mem_ready_i
    logic     wait_q;
    logic     owner_dc_q;
    logic     held;
    logic     pick_dc;
    logic     grant;
    mem_req_t sel_req;

    assign held    = busy_q || wait_q;
    assign pick_dc = held ? owner_dc_q : dc_req_i.valid;
    assign sel_req = pick_dc ? dc_req_i : ic_req_i;
    assign grant   = sel_req.valid && mem_ready_i;

    assign mem_req_o  = sel_req;
    assign ic_grant_o = grant && !pick_dc;
    assign dc_grant_o = grant && pick_dc;

    // response goes back to the owner only
    always_comb begin
        ic_rsp_o       = mem_rsp_i;
        dc_rsp_o       = mem_rsp_i;
        ic_rsp_o.valid = mem_rsp_i.valid && busy_q && !owner_dc_q;
        dc_rsp_o.valid = mem_rsp_i.valid && busy_q && owner_dc_q;
    end

    // a write grant keeps the data cache as owner until its refill returns
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_q     <= 1'b0;
            wait_q     <= 1'b0;
            owner_dc_q <= 1'b0;
        end else begin
            owner_dc_q <= pick_dc;
            wait_q     <= sel_req.valid && !mem_ready_i;
            if (mem_rsp_i.valid) begin
                busy_q <= 1'b0;
            end else if (grant) begin
                busy_q <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/l1_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module l1_mem_top
    import cache_pkg::*;
#(
    parameter int LINE_WORDS = 4,
    parameter int SETS       = 16
) (
    input  logic       clk,
    input  logic       rst_n_i,
    input  fetch_req_t fetch_req_i,
    output fetch_rsp_t fetch_rsp_o,
    output logic       fetch_stall_o,
    input  data_req_t  data_req_i,
    output data_rsp_t  data_rsp_o,
    output logic       data_stall_o,
    output mem_req_t   mem_req_o,
    input  logic       mem_ready_i,
    input  mem_rsp_t   mem_rsp_i
);

    mem_req_t ic_mem_req;
    mem_req_t dc_mem_req;
    logic     ic_grant;
    logic     dc_grant;
    mem_rsp_t ic_mem_rsp;
    mem_rsp_t dc_mem_rsp;

    icache #(
        .LINE_WORDS (LINE_WORDS),
        .SETS       (SETS)
    ) u_icache (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .req_i       (fetch_req_i),
        .rsp_o       (fetch_rsp_o),
        .stall_o     (fetch_stall_o),
        .mem_req_o   (ic_mem_req),
        .mem_grant_i (ic_grant),
        .mem_rsp_i   (ic_mem_rsp)
    );

    dcache #(
        .LINE_WORDS (LINE_WORDS),
        .SETS       (SETS)
    ) u_dcache (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .req_i       (data_req_i),
        .rsp_o       (data_rsp_o),
        .stall_o     (data_stall_o),
        .mem_req_o   (dc_mem_req),
        .mem_grant_i (dc_grant),
        .mem_rsp_i   (dc_mem_rsp)
    );

    // data side wins when both miss together
    mem_arbiter u_mem_arbiter (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .ic_req_i    (ic_mem_req),
        .dc_req_i    (dc_mem_req),
        .ic_grant_o  (ic_grant),
        .dc_grant_o  (dc_grant),
        .ic_rsp_o    (ic_mem_rsp),
        .dc_rsp_o    (dc_mem_rsp),
        .mem_req_o   (mem_req_o),
        .mem_ready_i (mem_ready_i),
        .mem_rsp_i   (mem_rsp_i)
    );

endmodule

`default_nettype wire

// ==== verification/tb_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_checker
    import cache_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    input  fetch_req_t fetch_req_i,
    input  fetch_rsp_t fetch_rsp_i,
    input  logic       fetch_stall_i,
    input  data_req_t  data_req_i,
    input  data_rsp_t  data_rsp_i,
    input  logic       data_stall_i,
    output int         error_count_o,
    output int         check_count_o,
    output logic       idle_o
);

    word_t shadow [addr_t];
    word_t fetch_exp_q [$];
    addr_t fetch_addr_q [$];
    word_t data_exp_q [$];
    addr_t data_addr_q [$];

    // initial content of external memory, by word address
    function automatic word_t init_word(addr_t wa);
        return (wa * 32'h9E37_79B1) ^ {wa[15:0], wa[31:16]} ^ 32'hA5C3_0F1E;
    endfunction

    function automatic word_t shadow_word(addr_t wa);
        if (shadow.exists(wa)) begin
            return shadow[wa];
        end
        return init_word(wa);
    endfunction

    initial begin
        error_count_o = 0;
        check_count_o = 0;
        idle_o        = 1'b1;
    end

    // sampled mid-cycle, where inputs and outputs are settled
    always @(negedge clk) begin
        word_t exp;
        word_t cur;
        addr_t wa;
        if (rst_n_i) begin
            if (fetch_rsp_i.valid) begin
                if (fetch_exp_q.size() == 0) begin
                    $display("checker: fetch response with no fetch outstanding");
                    error_count_o++;
                end else begin
                    exp = fetch_exp_q.pop_front();
                    wa  = fetch_addr_q.pop_front();
                    check_count_o++;
                    if (fetch_rsp_i.data !== exp) begin
                        $display("** Error fetch_rsp_o.data addr %h expected %h actual %h",
                                 wa, exp, fetch_rsp_i.data);
                        error_count_o++;
                    end
                end
            end
            if (data_rsp_i.valid) begin
                if (data_exp_q.size() == 0) begin
                    $display("checker: data response with no access outstanding");
                    error_count_o++;
                end else begin
                    exp = data_exp_q.pop_front();
                    wa  = data_addr_q.pop_front();
                    check_count_o++;
                    if (data_rsp_i.rdata !== exp) begin
                        $display("** Error data_rsp_o.rdata addr %h expected %h actual %h",
                                 wa, exp, data_rsp_i.rdata);
                        error_count_o++;
                    end
                end
            end
            if (fetch_req_i.valid && !fetch_stall_i) begin
                fetch_exp_q.push_back(init_word(fetch_req_i.addr >> 2));
                fetch_addr_q.push_back(fetch_req_i.addr);
            end
            if (data_req_i.valid && !data_stall_i) begin
                wa  = data_req_i.addr >> 2;
                cur = shadow_word(wa);
                if (data_req_i.write) begin
                    for (int b = 0; b < 4; b++) begin
                        if (data_req_i.strb[b]) begin
                            cur[b*8 +: 8] = data_req_i.wdata[b*8 +: 8];
                        end
                    end
                    shadow[wa] = cur;
                end
                data_exp_q.push_back(cur);
                data_addr_q.push_back(data_req_i.addr);
            end
        end
        idle_o = fetch_exp_q.size() == 0 && data_exp_q.size() == 0;
    end

endmodule

`default_nettype wire

// ==== verification/tb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_top
    import cache_pkg::*;
;

    localparam int    LINE_WORDS = 4;
    localparam int    SETS       = 16;
    localparam int    LINE_BYTES = LINE_WORDS * 4;
    localparam int    DATA_SPAN  = 4 * SETS * LINE_BYTES;
    localparam int    N_RAND     = 300;
    // directed tests issue well under this many requests
    localparam int    N_REQ      = 2 * N_RAND + 60;
    // three line transfers, each up to 6 cycles ready and 6 cycles response
    localparam int    WORST_MISS = 40;
    localparam longint TIMEOUT_NS = (N_REQ * WORST_MISS + 500) * 100;

    logic       clk;
    logic       rst_n_i;
    fetch_req_t fetch_req_i;
    fetch_rsp_t fetch_rsp_o;
    logic       fetch_stall_o;
    data_req_t  data_req_i;
    data_rsp_t  data_rsp_o;
    logic       data_stall_o;
    mem_req_t   mem_req_o;
    logic       mem_ready_i;
    mem_rsp_t   mem_rsp_i;

    int          tb_errors;
    int          chk_errors;
    int          chk_count;
    logic        chk_idle;
    word_t       ext_mem [addr_t];
    logic [32:0] xfer_log [$];

    initial clk = 1'b0;
    always #50 clk = ~clk;

    l1_mem_top #(
        .LINE_WORDS (LINE_WORDS),
        .SETS       (SETS)
    ) UUT (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .fetch_req_i   (fetch_req_i),
        .fetch_rsp_o   (fetch_rsp_o),
        .fetch_stall_o (fetch_stall_o),
        .data_req_i    (data_req_i),
        .data_rsp_o    (data_rsp_o),
        .data_stall_o  (data_stall_o),
        .mem_req_o     (mem_req_o),
        .mem_ready_i   (mem_ready_i),
        .mem_rsp_i     (mem_rsp_i)
    );

    tb_checker u_checker (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .fetch_req_i   (fetch_req_i),
        .fetch_rsp_i   (fetch_rsp_o),
        .fetch_stall_i (fetch_stall_o),
        .data_req_i    (data_req_i),
        .data_rsp_i    (data_rsp_o),
        .data_stall_i  (data_stall_o),
        .error_count_o (chk_errors),
        .check_count_o (chk_count),
        .idle_o        (chk_idle)
    );

    // same initial content as the checker's reference
    function automatic word_t mem_init_word(addr_t wa);
        return (wa * 32'h9E37_79B1) ^ {wa[15:0], wa[31:16]} ^ 32'hA5C3_0F1E;
    endfunction

    function automatic word_t mem_read_word(addr_t wa);
        if (ext_mem.exists(wa)) begin
            return ext_mem[wa];
        end
        return mem_init_word(wa);
    endfunction

    // external memory, one line per beat
    initial begin
        logic     xfer;
        logic     rd_pend;
        int       rd_wait;
        int       ready_wait;
        mem_req_t req_s;
        addr_t    rd_addr;
        mem_ready_i = 1'b0;
        mem_rsp_i   = '0;
        rd_pend     = 1'b0;
        rd_wait     = 0;
        ready_wait  = 0;
        rd_addr     = '0;
        forever begin
            @(negedge clk);
            xfer  = rst_n_i && mem_req_o.valid && mem_ready_i;
            req_s = mem_req_o;
            @(posedge clk);
            #1;
            mem_rsp_i.valid = 1'b0;
            if (xfer) begin
                xfer_log.push_back({req_s.write, req_s.addr});
                if (req_s.write) begin
                    for (int i = 0; i < LINE_WORDS; i++) begin
                        ext_mem[(req_s.addr >> 2) + i] = req_s.line[i*32 +: 32];
                    end
                end else begin
                    if (rd_pend) begin
                        $display("memory model: second read issued while one is outstanding");
                        tb_errors++;
                    end
                    rd_pend = 1'b1;
                    rd_addr = req_s.addr;
                    rd_wait = $urandom % 6;
                end
                ready_wait = $urandom % 6;
            end else if (ready_wait > 0) begin
                ready_wait--;
            end
            if (rd_pend) begin
                if (rd_wait == 0) begin
                    mem_rsp_i.valid = 1'b1;
                    mem_rsp_i.line  = '0;
                    for (int i = 0; i < LINE_WORDS; i++) begin
                        mem_rsp_i.line[i*32 +: 32] = mem_read_word((rd_addr >> 2) + i);
                    end
                    rd_pend = 1'b0;
                end else begin
                    rd_wait--;
                end
            end
            mem_ready_i = ready_wait == 0;
        end
    end

    task automatic fetch_word(input addr_t a);
        logic taken;
        fetch_req_i.valid = 1'b1;
        fetch_req_i.addr  = a;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = !fetch_stall_o;
            @(posedge clk);
            #1;
        end
    endtask

    task automatic data_access(input logic wr, input strb_t s, input addr_t a, input word_t d);
        logic taken;
        data_req_i.valid = 1'b1;
        data_req_i.write = wr;
        data_req_i.strb  = s;
        data_req_i.addr  = a;
        data_req_i.wdata = d;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = !data_stall_o;
            @(posedge clk);
            #1;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_idle();
        fetch_req_i.valid = 1'b0;
        data_req_i.valid  = 1'b0;
        do begin
            next_cycle();
        end while (!chk_idle);
    endtask

    // the line is resident, so every fetch must respond one cycle later
    task automatic check_fetch_stream(input addr_t base);
        for (int i = 1; i < LINE_WORDS; i++) begin
            fetch_req_i.valid = 1'b1;
            fetch_req_i.addr  = base + i * 4;
            @(negedge clk);
            if (fetch_stall_o) begin
                $display("fetch stalled on a resident line at %h", base + i * 4);
                tb_errors++;
            end
            if (i > 1 && !fetch_rsp_o.valid) begin
                $display("fetch hit gave no response one cycle after acceptance");
                tb_errors++;
            end
            next_cycle();
        end
        fetch_req_i.valid = 1'b0;
        @(negedge clk);
        if (!fetch_rsp_o.valid) begin
            $display("last fetch hit gave no response one cycle after acceptance");
            tb_errors++;
        end
        next_cycle();
    endtask

    function automatic int find_xfer(input logic wr, input addr_t a);
        for (int i = 0; i < xfer_log.size(); i++) begin
            if (xfer_log[i] == {wr, a}) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic random_fetches();
        for (int n = 0; n < N_RAND; n++) begin
            fetch_word(($urandom % 32'h1000) & ~32'h3);
            if ($urandom % 4 == 0) begin
                fetch_req_i.valid = 1'b0;
                repeat ($urandom % 3) next_cycle();
            end
        end
        fetch_req_i.valid = 1'b0;
    endtask

    task automatic random_data();
        for (int n = 0; n < N_RAND; n++) begin
            data_access($urandom % 2, $urandom % 16,
                        32'h1000 + (($urandom % DATA_SPAN) & ~32'h3), $urandom);
            if ($urandom % 4 == 0) begin
                data_req_i.valid = 1'b0;
                repeat ($urandom % 3) next_cycle();
            end
        end
        data_req_i.valid = 1'b0;
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: run did not finish in time, responses may be missing");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int    wb_idx;
        int    rd_idx;
        addr_t a_line;
        addr_t b_line;
        addr_t c_line;
        addr_t d_line;
        void'($urandom(10911));
        tb_errors   = 0;
        rst_n_i     = 1'b0;
        fetch_req_i = '0;
        data_req_i  = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n_i = 1'b1;

        // outputs quiet after reset
        @(negedge clk);
        if (fetch_stall_o || data_stall_o || fetch_rsp_o.valid || data_rsp_o.valid ||
            mem_req_o.valid) begin
            $display("stall, response or memory request active right after reset");
            tb_errors++;
        end
        next_cycle();

        // first fetch misses, then the rest of the line hits
        fetch_word(32'h0100);
        wait_idle();
        check_fetch_stream(32'h0100);
        wait_idle();

        // stores with strobes, then loads, on a hit line and on allocate misses
        c_line = 32'h1400;
        data_access(1'b0, 4'h0, c_line, '0);
        for (int i = 0; i < LINE_WORDS; i++) begin
            data_access(1'b1, ($urandom % 15) + 1, c_line + i * 4, $urandom);
        end
        for (int i = 0; i < LINE_WORDS; i++) begin
            data_access(1'b0, 4'h0, c_line + i * 4, '0);
        end
        d_line = 32'h1800;
        data_access(1'b1, 4'b0110, d_line, 32'hDEAD_BEEF);
        data_access(1'b0, 4'h0, d_line, '0);
        data_access(1'b1, 4'b1001, d_line + 4, 32'h1234_5678);
        data_access(1'b0, 4'h0, d_line + 4, '0);
        wait_idle();

        // dirty victim goes out before the conflicting line comes in
        a_line = 32'h3000;
        b_line = a_line + SETS * LINE_BYTES;
        data_access(1'b1, 4'b1111, a_line + 4, 32'hCAFE_F00D);
        wait_idle();
        xfer_log.delete();
        data_access(1'b0, 4'h0, b_line, '0);
        data_access(1'b0, 4'h0, a_line + 4, '0);
        wait_idle();
        wb_idx = find_xfer(1'b1, a_line);
        rd_idx = find_xfer(1'b0, b_line);
        if (wb_idx < 0 || rd_idx < 0 || wb_idx > rd_idx) begin
            $display("dirty line was not written back before the conflicting refill");
            tb_errors++;
        end

        // simultaneous misses, data side first
        xfer_log.delete();
        fork
            fetch_word(32'h0800);
            data_access(1'b0, 4'h0, 32'h2400, '0);
        join
        wait_idle();
        if (xfer_log.size() < 2 || xfer_log[0][31:0] < 32'h1000) begin
            $display("data cache miss was not granted before the fetch miss");
            tb_errors++;
        end

        fork
            random_fetches();
            random_data();
        join
        wait_idle();
        repeat (4) next_cycle();

        $display("checks: %0d  errors: %0d", chk_count, tb_errors + chk_errors);
        if (tb_errors + chk_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
rtl/cache_pkg.sv
rtl/cache_array.sv
rtl/icache.sv
rtl/dcache.sv
rtl/mem_arbiter.sv
rtl/l1_mem_top.sv
verification/tb_checker.sv
verification/tb_top.sv

// ==== Makefile ====
# Verilator build and run of the L1 memory testbench

OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -Wno-fatal -f all.f --top-module tb_top -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/Vtb_top)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
